// ==== rtl/intc_pkg.sv ====
`default_nettype none

package intc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Controller limits
    ////////////////////////////////////////////////////////////////////////////

    // Status and control words leave room for this many sources
    localparam int MAX_SOURCES = 8;

    ////////////////////////////////////////////////////////////////////////////
    // Common word and index types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] intc_word_t;   // Data, address and ISR vector
    typedef logic [2:0]  src_idx_t;     // Enough for MAX_SOURCES

    // Source currently in service, latched by the sequencer
    typedef struct packed {
        logic       valid;              // Grant held while IRQ is raised or about to be
        src_idx_t   idx;                // Winning source
        intc_word_t vector;             // Vector copied at grant time
    } intc_grant_t;

endpackage : intc_pkg

`default_nettype wire

// ==== rtl/intc_regmap_pkg.sv ====
`default_nettype none

package intc_regmap_pkg;

    import intc_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Byte offsets seen on input_addr
    ////////////////////////////////////////////////////////////////////////////

    localparam intc_word_t REG_CTRL     = 32'h0000_0000;  // Global enable and mask
    localparam intc_word_t REG_STATUS   = 32'h0000_0004;  // Read only
    localparam intc_word_t REG_VEC_BASE = 32'h0000_0010;  // Vector n at base + 4n

    ////////////////////////////////////////////////////////////////////////////
    // Register word layouts
    ////////////////////////////////////////////////////////////////////////////

    // Control word
    typedef struct packed {
        logic [31-MAX_SOURCES-1:0] reserved;    // Reads back as zero
        logic                      global_en;   // Bit 8
        logic [MAX_SOURCES-1:0]    enable;      // Per-source mask
    } intc_ctrl_t;

    // One write word with two meanings by target address
    typedef union packed {
        intc_ctrl_t ctrl;   // REG_CTRL view
        intc_word_t vec;    // Vector slot view
    } intc_reg_word_u;

endpackage : intc_regmap_pkg

`default_nettype wire

// ==== rtl/intc_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module intc_regfile
    import intc_pkg::*;
    import intc_regmap_pkg::*;
#(
    parameter int NUM_SOURCES = 4
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire intc_word_t        input_addr,
    input  wire intc_word_t        write_data,
    input  wire                    write_enable,
    input  wire [NUM_SOURCES-1:0]  pending,
    input  wire intc_grant_t       grant,
    output intc_word_t             read_data,
    output logic [NUM_SOURCES-1:0] enable,
    output intc_word_t             vectors [NUM_SOURCES]
);

    intc_reg_word_u         wr_word;    // Write data in both views
    intc_ctrl_t             ctrl_q;
    logic [NUM_SOURCES-1:0] vec_wr;     // One-hot vector slot write
    logic [MAX_SOURCES-1:0] pend_ext;
    intc_word_t             status_w;
    intc_word_t             rd_mux;

    // Byte address of vector slot n
    function automatic intc_word_t vec_addr(input int n);
        return REG_VEC_BASE + intc_word_t'(4 * n);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////////////////////

    assign wr_word = write_data;

    always_comb begin
        for (int n = 0; n < NUM_SOURCES; n++) begin
            vec_wr[n] = write_enable && (input_addr == vec_addr(n));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q <= '0;                                   // Everything masked
        end else if (write_enable && input_addr == REG_CTRL) begin
            ctrl_q <= '{reserved: '0,
                        global_en: wr_word.ctrl.global_en,
                        enable: wr_word.ctrl.enable};
        end
    end

    always_ff @(posedge clk) begin
        for (int n = 0; n < NUM_SOURCES; n++) begin
            if (reset) vectors[n] <= '0;
            else if (vec_wr[n]) vectors[n] <= wr_word.vec;  // Address view
        end
    end

    // Global enable gates the whole mask
    assign enable = ctrl_q.enable[NUM_SOURCES-1:0] & {NUM_SOURCES{ctrl_q.global_en}};

    ////////////////////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        pend_ext = '0;
        pend_ext[NUM_SOURCES-1:0] = pending;
    end

    // idx at 18:16, service flag at 8, pending at 7:0
    assign status_w = {13'b0, grant.idx, 7'b0, grant.valid, pend_ext};

    always_comb begin
        rd_mux = '0;                                        // Unmapped reads zero
        if (input_addr == REG_CTRL)   rd_mux = ctrl_q;
        if (input_addr == REG_STATUS) rd_mux = status_w;
        for (int n = 0; n < NUM_SOURCES; n++) begin
            if (input_addr == vec_addr(n)) rd_mux = vectors[n];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) read_data <= '0;
        else       read_data <= rd_mux;                     // One cycle after address
    end

    // Table only moves under an explicit write while a source is served
    for (genvar n = 0; n < NUM_SOURCES; n++) begin : g_vec_chk
        a_vec_hold: assert property (@(posedge clk) disable iff (reset)
            grant.valid && !vec_wr[n] |=> $stable(vectors[n]))
            else $error("vector %0d changed during service without a write", n);
    end

endmodule : intc_regfile

`default_nettype wire

// ==== rtl/intc_pending.sv ====
`timescale 1ns/1ps
`default_nettype none

module intc_pending
    import intc_pkg::*;
#(
    parameter int NUM_SOURCES = 4
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire [NUM_SOURCES-1:0]  done,
    input  wire                    ack_clear,
    input  wire src_idx_t          ack_idx,
    output logic [NUM_SOURCES-1:0] pending
);

    logic [NUM_SOURCES-1:0] done_q;     // Last cycle's done levels
    logic [NUM_SOURCES-1:0] rise;
    logic [NUM_SOURCES-1:0] clr;        // Decoded acknowledge
    logic [NUM_SOURCES-1:0] rearm;      // Edge seen while already pending

    assign rise = done & ~done_q;

    always_comb begin
        for (int i = 0; i < NUM_SOURCES; i++) begin
            clr[i] = ack_clear && (ack_idx == src_idx_t'(i));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pending latch
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            done_q  <= '0;
            pending <= '0;
            rearm   <= '0;
        end else begin
            done_q  <= done;
            // Set beats clear and a stored second edge survives the clear
            pending <= (pending & ~clr) | rise | (clr & rearm);
            rearm   <= (rearm & ~clr) | (rise & pending & ~clr);
        end
    end

    // Only the sequencer's clear may drop a bit
    for (genvar i = 0; i < NUM_SOURCES; i++) begin : g_fall_chk
        a_fall_on_clear: assert property (@(posedge clk) disable iff (reset)
            $fell(pending[i]) |-> $past(clr[i]))
            else $error("pending[%0d] dropped without an acknowledge", i);
    end

endmodule : intc_pending

`default_nettype wire

// ==== rtl/intc_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module intc_sequencer
    import intc_pkg::*;
#(
    parameter int NUM_SOURCES = 4
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire [NUM_SOURCES-1:0] pending,
    input  wire [NUM_SOURCES-1:0] enable,
    input  wire intc_word_t       vectors [NUM_SOURCES],
    input  wire                   iack,
    output intc_grant_t           grant,
    output logic                  irq,
    output intc_word_t            isr_addr,
    output logic                  ack_clear,
    output src_idx_t              ack_idx
);

    typedef enum logic [1:0] {S_IDLE, S_ACTIVE, S_RECOVER} state_t;

    state_t                 state;
    logic [NUM_SOURCES-1:0] req;
    logic                   iack_q;
    logic                   iack_rise;
    src_idx_t               sel_idx;
    intc_word_t             sel_vec;

    assign req       = pending & enable;
    assign iack_rise = iack & ~iack_q;

    // Lowest index wins, so scan from the top down
    always_comb begin
        sel_idx = '0;
        sel_vec = '0;
        for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
            if (req[i]) begin
                sel_idx = src_idx_t'(i);
                sel_vec = vectors[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Grant FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_IDLE;
            grant     <= '0;
            iack_q    <= 1'b0;
            ack_clear <= 1'b0;
            ack_idx   <= '0;
        end else begin
            iack_q    <= iack;
            ack_clear <= 1'b0;                              // Single-cycle pulse
            case (state)
                S_IDLE: if (|req) begin
                    grant <= '{valid: 1'b1, idx: sel_idx, vector: sel_vec};
                    state <= S_ACTIVE;
                end
                S_ACTIVE: if (iack_rise) begin
                    ack_clear   <= 1'b1;
                    ack_idx     <= grant.idx;
                    grant.valid <= 1'b0;                    // irq falls next cycle
                    state       <= S_RECOVER;
                end
                S_RECOVER: state <= S_IDLE;                 // Let pending settle
                default:   state <= S_IDLE;
            endcase
        end
    end

    // Outputs trail the grant by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            irq      <= 1'b0;
            isr_addr <= '0;
        end else begin
            irq <= grant.valid;
            if (grant.valid && !irq) isr_addr <= grant.vector;
        end
    end

    a_isr_stable: assert property (@(posedge clk) disable iff (reset)
        irq && $past(irq) |-> $stable(isr_addr))
        else $error("isr_addr moved while irq was high");

endmodule : intc_sequencer

`default_nettype wire

// ==== rtl/intc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module intc_top
    import intc_pkg::*;
#(
    parameter int NUM_SOURCES = 4
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire [NUM_SOURCES-1:0] done,
    input  wire                   iack,
    input  wire intc_word_t       input_addr,
    input  wire                   write_enable,
    input  wire intc_word_t       write_data,
    output intc_word_t            read_data,
    output logic                  irq,
    output intc_word_t            isr_addr
);

    logic [NUM_SOURCES-1:0] enable;     // Mask already gated by global_en
    intc_word_t             vectors [NUM_SOURCES];
    logic [NUM_SOURCES-1:0] pending;
    intc_grant_t            grant;
    logic                   ack_clear;
    src_idx_t               ack_idx;

    ////////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////////

    intc_regfile #(.NUM_SOURCES(NUM_SOURCES)) u_regfile (
        .clk(clk), .reset(reset),
        .input_addr(input_addr), .write_data(write_data), .write_enable(write_enable),
        .pending(pending), .grant(grant),
        .read_data(read_data), .enable(enable), .vectors(vectors)
    );

    intc_pending #(.NUM_SOURCES(NUM_SOURCES)) u_pending (
        .clk(clk), .reset(reset),
        .done(done), .ack_clear(ack_clear), .ack_idx(ack_idx),
        .pending(pending)
    );

    intc_sequencer #(.NUM_SOURCES(NUM_SOURCES)) u_sequencer (
        .clk(clk), .reset(reset),
        .pending(pending), .enable(enable), .vectors(vectors), .iack(iack),
        .grant(grant), .irq(irq), .isr_addr(isr_addr),
        .ack_clear(ack_clear), .ack_idx(ack_idx)
    );

endmodule : intc_top

`default_nettype wire

// ==== rtl/intc_dut_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module intc_dut_wrapper
    import intc_pkg::*;
#(
    parameter int C_S_AXI_DATA_WIDTH = 32,
    parameter int NUM_SOURCES        = 4
) (
    input  wire  [C_S_AXI_DATA_WIDTH-1:0] read_from_slv_reg0,   // done
    input  wire  [C_S_AXI_DATA_WIDTH-1:0] read_from_slv_reg1,   // input_addr
    input  wire  [C_S_AXI_DATA_WIDTH-1:0] read_from_slv_reg2,   // write_data
    input  wire  [C_S_AXI_DATA_WIDTH-1:0] read_from_slv_reg3,   // write_enable
    input  wire  [C_S_AXI_DATA_WIDTH-1:0] read_from_slv_reg4,   // iack
    output logic [C_S_AXI_DATA_WIDTH-1:0] write_to_slv_reg5,    // irq
    output logic [C_S_AXI_DATA_WIDTH-1:0] write_to_slv_reg6,    // isr_addr
    output logic [C_S_AXI_DATA_WIDTH-1:0] write_to_slv_reg7,    // read_data
    input  wire                           sysclk,
    input  wire                           reset
);

    logic [NUM_SOURCES-1:0] done;
    intc_word_t             input_addr;
    intc_word_t             write_data;
    logic                   write_enable;
    logic                   iack;
    logic                   irq;
    intc_word_t             isr_addr;
    intc_word_t             read_data;

    ////////////////////////////////////////////////////////////////////////////
    // Slave register slicing
    ////////////////////////////////////////////////////////////////////////////

    assign done         = read_from_slv_reg0[NUM_SOURCES-1:0];
    assign input_addr   = read_from_slv_reg1[31:0];
    assign write_data   = read_from_slv_reg2[31:0];
    assign write_enable = read_from_slv_reg3[0];
    assign iack         = read_from_slv_reg4[0];        // Acknowledge level

    assign write_to_slv_reg5 = C_S_AXI_DATA_WIDTH'(irq);        // Bit 0 only
    assign write_to_slv_reg6 = C_S_AXI_DATA_WIDTH'(isr_addr);
    assign write_to_slv_reg7 = C_S_AXI_DATA_WIDTH'(read_data);

    intc_top #(.NUM_SOURCES(NUM_SOURCES)) u_intc (
        .clk(sysclk),
        .reset(reset),
        .done(done),
        .iack(iack),
        .input_addr(input_addr),
        .write_enable(write_enable),
        .write_data(write_data),
        .read_data(read_data),
        .irq(irq),
        .isr_addr(isr_addr)
    );

endmodule : intc_dut_wrapper

`default_nettype wire

// ==== testbench/tb_intc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_intc
    import intc_pkg::*;
    import intc_regmap_pkg::*;
;

    localparam int NUM_SOURCES    = 4;
    localparam int CLK_PERIOD     = 8;
    localparam int DIRECTED_STEPS = 5;
    localparam int RANDOM_ITERS   = 40;
    localparam int SETTLE         = 8;     // Long enough for edge, grant and irq

    logic        clk;
    logic        reset;
    logic [31:0] slv0;                     // done
    logic [31:0] slv1;                     // addr
    logic [31:0] slv2;                     // data
    logic [31:0] slv3;                     // we
    logic [31:0] slv4;                     // iack
    logic [31:0] slv5;                     // irq
    logic [31:0] slv6;                     // isr_addr
    logic [31:0] slv7;                     // read_data
    logic        irq;
    intc_word_t  isr_addr;
    intc_word_t  read_data;

    int mismatch_count = 0;
    int fail_count     = 0;
    int seed           = 73894;

    // Reference state updated as stimulus is driven
    intc_word_t             m_ctrl;
    intc_word_t             m_vec [NUM_SOURCES];
    logic [NUM_SOURCES-1:0] m_pend;
    logic [NUM_SOURCES-1:0] m_rearm;        // Second edge while already pending
    logic                   m_svc;
    src_idx_t               m_idx;          // Last granted source kept after ack
    intc_word_t             m_svc_vec;

    // Read expected by the comparing process
    intc_word_t rd_exp;
    string      rd_name;
    int         rd_age = 0;

    assign irq       = slv5[0];
    assign isr_addr  = slv6;
    assign read_data = slv7;

    intc_dut_wrapper #(.C_S_AXI_DATA_WIDTH(32), .NUM_SOURCES(NUM_SOURCES)) u_dut (
        .read_from_slv_reg0(slv0), .read_from_slv_reg1(slv1), .read_from_slv_reg2(slv2),
        .read_from_slv_reg3(slv3), .read_from_slv_reg4(slv4),
        .write_to_slv_reg5(slv5), .write_to_slv_reg6(slv6), .write_to_slv_reg7(slv7),
        .sysclk(clk), .reset(reset)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic intc_word_t vector_address(input int n);
        return REG_VEC_BASE + 32'(4 * n);
    endfunction

    // Pending and enabled requests with global_en at bit 8 gating the mask
    function automatic logic [NUM_SOURCES-1:0] enabled_requests();
        return m_pend & (m_ctrl[8] ? m_ctrl[NUM_SOURCES-1:0] : '0);
    endfunction

    function automatic int lowest_request();
        logic [NUM_SOURCES-1:0] req;
        req = enabled_requests();
        for (int i = 0; i < NUM_SOURCES; i++) begin
            if (req[i]) return i;
        end
        return -1;                          // Nothing to grant
    endfunction

    function automatic intc_word_t ref_read(input intc_word_t addr);
        intc_word_t w;
        w = '0;                             // Unmapped
        if (addr == REG_CTRL) begin
            w = m_ctrl;
        end else if (addr == REG_STATUS) begin
            w[NUM_SOURCES-1:0] = m_pend;
            w[8]               = m_svc;
            w[18:16]           = m_idx;
        end else begin
            for (int n = 0; n < NUM_SOURCES; n++) begin
                if (addr == vector_address(n)) w = m_vec[n];
            end
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input intc_word_t got, input intc_word_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_irq(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_reg(input intc_word_t addr, input intc_word_t data);
        @(posedge clk);
        slv1 <= addr;
        slv2 <= data;
        slv3 <= 32'd1;
        if (addr == REG_CTRL) m_ctrl = data & 32'h0000_01FF;   // Reserved bits read zero
        for (int n = 0; n < NUM_SOURCES; n++) begin
            if (addr == vector_address(n)) m_vec[n] = data;
        end
        @(posedge clk);
        slv3 <= 32'd0;
    endtask

    // One-cycle high level on the chosen done bits
    task automatic pulse_done(input logic [NUM_SOURCES-1:0] bits);
        @(posedge clk);
        slv0 <= 32'(bits);
        for (int b = 0; b < NUM_SOURCES; b++) begin
            if (bits[b] && m_pend[b]) m_rearm[b] = 1'b1;
            else if (bits[b])         m_pend[b]  = 1'b1;
        end
        @(posedge clk);
        slv0 <= 32'd0;
    endtask

    task automatic wait_irq(input logic level, input int max_cycles);
        int waited;
        waited = 1;
        @(negedge clk);
        while (irq !== level && waited < max_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (irq !== level) begin
            fail_count++;
            $display("ERROR t=%0t irq did not go to %0b within %0d cycles",
                     $time, level, max_cycles);
        end
    endtask

    task automatic acknowledge();
        @(posedge clk);
        slv4 <= 32'd1;
        if (m_rearm[m_idx]) m_rearm[m_idx] = 1'b0;    // Extra edge keeps it pending
        else                m_pend[m_idx]  = 1'b0;
        m_svc = 1'b0;
        @(posedge clk);
        slv4 <= 32'd0;
        wait_irq(1'b0, 3);
    endtask

    // Arms the comparing process, which checks one cycle after the address
    task automatic read_check(input intc_word_t addr);
        @(posedge clk);
        slv1    <= addr;
        rd_exp  = ref_read(addr);
        rd_name = $sformatf("read_data@%h", addr);
        rd_age  = 2;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic settle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic check_idle_irq();
        logic exp;
        @(negedge clk);
        exp = m_svc || (|enabled_requests());
        check_irq("irq", irq, exp);
        check_word("write_to_slv_reg5", slv5, intc_word_t'(exp));  // Upper bits stay zero
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Comparing process
    ////////////////////////////////////////////////////////////////////////////

    initial begin : compare
        logic irq_q;
        int   lowest;
        irq_q = 1'b0;
        forever begin
            @(negedge clk);
            if (irq && !irq_q) begin                    // New interrupt
                lowest = lowest_request();
                if (lowest < 0) begin
                    fail_count++;
                    $display("ERROR t=%0t irq raised with no enabled pending source", $time);
                end else begin
                    m_idx     = src_idx_t'(lowest);
                    m_svc_vec = m_vec[lowest];
                    check_word("isr_addr", isr_addr, m_svc_vec);
                end
                m_svc = 1'b1;
            end
            irq_q = irq;
            if (rd_age != 0) begin
                rd_age--;
                if (rd_age == 0) check_word(rd_name, read_data, rd_exp);
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (200 * DIRECTED_STEPS + 60 * RANDOM_ITERS));
        fail_count++;
        $display("ERROR t=%0t timeout, the tests did not finish in time", $time);
        $display("errors: mismatches=%0d other=%0d", mismatch_count, fail_count);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] r;
        reset = 1'b1;
        slv0 = '0;
        slv1 = '0;
        slv2 = '0;
        slv3 = '0;
        slv4 = '0;
        m_ctrl = '0;
        m_pend = '0;
        m_rearm = '0;
        m_svc = 1'b0;
        m_idx = '0;
        m_svc_vec = '0;
        for (int n = 0; n < NUM_SOURCES; n++) m_vec[n] = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Read-back with reset values first
        check_idle_irq();
        check_word("isr_addr", isr_addr, '0);
        read_check(REG_STATUS);
        write_reg(REG_CTRL, 32'hFFFF_FE05);                 // global_en clear
        for (int n = 0; n < NUM_SOURCES; n++) begin
            write_reg(vector_address(n), 32'hA000_0000 + 32'(n * 32'h111));
        end
        read_check(REG_CTRL);
        for (int n = 0; n < NUM_SOURCES; n++) read_check(vector_address(n));
        read_check(32'h0000_0008);
        read_check(32'h0000_0020);                          // Just past the table

        // Single interrupt on source 1
        write_reg(REG_CTRL, 32'h0000_0102);
        pulse_done(4'b0010);
        wait_irq(1'b1, 3);
        read_check(REG_STATUS);
        acknowledge();
        settle(2);
        read_check(REG_STATUS);

        // Priority with three sources at once
        write_reg(REG_CTRL, 32'h0000_010F);
        pulse_done(4'b1101);
        repeat (3) begin
            wait_irq(1'b1, 6);
            acknowledge();
        end
        settle(SETTLE);
        check_idle_irq();
        read_check(REG_STATUS);

        // Masking by mask bit and then by global_en
        write_reg(REG_CTRL, 32'h0000_0101);
        pulse_done(4'b0100);
        settle(SETTLE);
        check_idle_irq();
        read_check(REG_STATUS);
        write_reg(REG_CTRL, 32'h0000_0105);
        wait_irq(1'b1, 6);
        acknowledge();
        write_reg(REG_CTRL, 32'h0000_000F);
        pulse_done(4'b1000);
        settle(SETTLE);
        check_idle_irq();
        write_reg(REG_CTRL, 32'h0000_010F);
        wait_irq(1'b1, 6);
        acknowledge();

        // Vector rewrite while source 0 is in service
        write_reg(REG_CTRL, 32'h0000_0101);
        pulse_done(4'b0001);
        wait_irq(1'b1, 3);
        write_reg(vector_address(0), 32'h0BAD_F00D);
        settle(3);
        @(negedge clk);
        check_word("isr_addr", isr_addr, m_svc_vec);        // Latched value held
        acknowledge();
        settle(SETTLE);
        pulse_done(4'b0001);
        wait_irq(1'b1, 3);
        acknowledge();
        settle(SETTLE);

        // Random edges, mask writes and acknowledges
        for (int it = 0; it < RANDOM_ITERS; it++) begin
            r = $random(seed);
            if (r[1:0] == 2'd2) begin
                write_reg(REG_CTRL, {23'b0, r[12] | r[13], 4'b0, r[19:16]});
            end else if (r[1:0] == 2'd3 && m_svc) begin
                acknowledge();
            end else begin
                pulse_done(r[7:4] | (4'b0001 << r[9:8]));
            end
            settle(SETTLE);
            check_idle_irq();
            read_check(REG_STATUS);
        end
        settle(4);

        $display("errors: mismatches=%0d other=%0d", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tb_intc

`default_nettype wire

// ==== intc_dut_wrapper.f ====
rtl/intc_pkg.sv
rtl/intc_regmap_pkg.sv
rtl/intc_regfile.sv
rtl/intc_pending.sv
rtl/intc_sequencer.sv
rtl/intc_top.sv
rtl/intc_dut_wrapper.sv
testbench/tb_intc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the interrupt controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f intc_dut_wrapper.f \
    --top-module tb_intc \
    -o sim_intc

./obj_dir/sim_intc | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q "TB PASSED" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi

echo "Simulation passed"
